// ==== list.f ====
+incdir+logic
+incdir+tb
logic/core_pkg.sv
logic/reg_file.sv
logic/fetch_unit.sv
logic/decode_unit.sv
logic/exec_unit.sv
logic/core_top.sv
tb/tb_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f list.f --top-module tb_top \
	-Mdir obj_dir -o tb_top_sim > build.log 2>&1
status=$?
if [ $status -ne 0 ]; then
	cat build.log
	echo "build failed with status $status"
	exit 1
fi

./obj_dir/tb_top_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q -x "Finished with errors" sim.log; then
	exit 1
fi
exit 0

// ==== tb/isa_model.svh ====
// test program and reference model
`ifndef ISA_MODEL_SVH
`define ISA_MODEL_SVH

	localparam int PROG_LEN = 23;

	// instruction kinds of the test program
	typedef enum logic [2:0] {
		k_add,
		k_addi,
		k_lui,
		k_beq,
		k_bne,
		k_jal,
		k_raw
	} kind_e;

	// symbolic instruction with the raw word in imm for k_raw
	typedef struct packed {
		kind_e       kind;
		logic [4:0]  rd;
		logic [4:0]  rs1;
		logic [4:0]  rs2;
		logic [31:0] imm;
	} sym_inst_t;

	function automatic sym_inst_t make_inst(input kind_e kind, input logic [4:0] rd,
		input logic [4:0] rs1, input logic [4:0] rs2, input logic [31:0] imm);
		sym_inst_t s;
		s.kind = kind;
		s.rd = rd;
		s.rs1 = rs1;
		s.rs2 = rs2;
		s.imm = imm;
		return s;
	endfunction

	// byte address is four times the index
	function automatic sym_inst_t program_entry(input int idx);
		case (idx)
			0: return make_inst(k_addi, 1, 0, 0, 5);
			1: return make_inst(k_addi, 2, 0, 0, -3);
			2: return make_inst(k_add, 3, 1, 2, 0);
			3: return make_inst(k_lui, 4, 0, 0, 32'hABCD_E000);
			4: return make_inst(k_addi, 0, 1, 0, 7);
			5: return make_inst(k_lui, 0, 0, 0, 32'h1234_5000);
			6: return make_inst(k_add, 5, 0, 3, 0);
			7: return make_inst(k_beq, 0, 3, 5, 8);
			8: return make_inst(k_addi, 6, 0, 0, 1);
			9: return make_inst(k_bne, 0, 3, 5, 8);
			10: return make_inst(k_beq, 0, 1, 2, 12);
			11: return make_inst(k_bne, 0, 1, 2, 8);
			12: return make_inst(k_addi, 6, 0, 0, 2);
			13: return make_inst(k_jal, 7, 0, 0, 8);
			14: return make_inst(k_addi, 6, 0, 0, 3);
			// custom-0 opcode
			15: return make_inst(k_raw, 0, 0, 0, 32'h0000_000B);
			// sub x8, x1, x2 is outside the subset
			16: return make_inst(k_raw, 0, 0, 0, 32'h4020_8433);
			17: return make_inst(k_add, 8, 3, 4, 0);
			18: return make_inst(k_lui, 9, 0, 0, 32'h8000_0000);
			19: return make_inst(k_addi, 9, 9, 0, -1);
			20: return make_inst(k_addi, 11, 11, 0, 1);
			21: return make_inst(k_bne, 0, 11, 3, -48);
			22: return make_inst(k_jal, 10, 0, 0, -88);
			default: return make_inst(k_raw, 0, 0, 0, 32'h0000_000B);
		endcase
	endfunction

	// assembles the RV32I encoding
	function automatic logic [31:0] encode(input sym_inst_t s);
		case (s.kind)
			k_add: return {7'b0, s.rs2, s.rs1, 3'b000, s.rd, 7'b0110011};
			k_addi: return {s.imm[11:0], s.rs1, 3'b000, s.rd, 7'b0010011};
			k_lui: return {s.imm[31:12], s.rd, 7'b0110111};
			k_beq: return {s.imm[12], s.imm[10:5], s.rs2, s.rs1, 3'b000,
				s.imm[4:1], s.imm[11], 7'b1100011};
			k_bne: return {s.imm[12], s.imm[10:5], s.rs2, s.rs1, 3'b001,
				s.imm[4:1], s.imm[11], 7'b1100011};
			k_jal: return {s.imm[20], s.imm[10:1], s.imm[11], s.imm[19:12],
				s.rd, 7'b1101111};
			default: return s.imm;
		endcase
	endfunction

	function automatic logic in_program(input logic [31:0] addr);
		return (addr[1:0] == 2'b00) && (int'(addr[31:2]) < PROG_LEN);
	endfunction

	// unused space reads as custom-0 words tagged with the address
	function automatic logic [31:0] fetch_word(input logic [31:0] addr);
		logic [31:0] word;
		if (in_program(addr)) begin
			word = encode(program_entry(int'(addr[31:2])));
		end else begin
			word = {addr[31:7] ^ addr[24:0], 7'b0001011};
		end
		return word;
	endfunction

	// taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] state);
		logic feedback;
		feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
		return {state[30:0], feedback};
	endfunction

	// executes the program and fills exp_commit in retire order
	function automatic void run_model();
		logic [31:0] regs [32];
		logic [31:0] pc;
		logic [31:0] next_pc;
		logic [31:0] src1;
		logic [31:0] src2;
		sym_inst_t   s;
		commit_exp_t e;
		for (int i = 0; i < 32; i++) begin
			regs[i] = '0;
		end
		pc = `CORE_RESET_PC;
		for (int n = 0; n < NUM_COMMITS; n++) begin
			s = program_entry(int'(pc >> 2));
			src1 = regs[s.rs1];
			src2 = regs[s.rs2];
			next_pc = pc + `CORE_PC_STEP;
			e = '0;
			e.pc = pc;
			e.rd = s.rd;
			case (s.kind)
				k_add: begin
					e.data = src1 + src2;
					e.has_result = 1'b1;
				end
				k_addi: begin
					e.data = src1 + s.imm;
					e.has_result = 1'b1;
				end
				k_lui: begin
					e.data = s.imm;
					e.has_result = 1'b1;
				end
				k_beq: begin
					if (src1 == src2) begin
						next_pc = pc + s.imm;
					end
				end
				k_bne: begin
					if (src1 != src2) begin
						next_pc = pc + s.imm;
					end
				end
				k_jal: begin
					e.data = pc + `CORE_PC_STEP;
					e.has_result = 1'b1;
					next_pc = pc + s.imm;
				end
				default: begin
					e.has_result = 1'b0;
				end
			endcase
			// x0 stays zero
			if (e.has_result && s.rd != 5'd0) begin
				e.wen = 1'b1;
				regs[s.rd] = e.data;
			end
			exp_commit[n] = e;
			pc = next_pc;
		end
	endfunction

`endif

// ==== tb/tb_top.sv ====
// core testbench
`timescale 1ns/1ps
`default_nettype none
`include "core_defines.svh"

module tb_top;

	localparam int NUM_COMMITS = 48;
	localparam int TIMEOUT_CYCLES = 16 + NUM_COMMITS * 25;

	// one expected retirement
	typedef struct packed {
		logic [31:0] pc;
		logic [4:0]  rd;
		logic [31:0] data;
		logic        wen;
		logic        has_result;
	} commit_exp_t;

	logic                        clk = 1'b0;
	logic                        rst = 1'b1;
	logic [`CORE_DATA_WIDTH-1:0] araddr;
	logic                        arvalid;
	logic                        arready = 1'b0;
	logic [`CORE_DATA_WIDTH-1:0] rdata = '0;
	logic                        rvalid = 1'b0;
	logic                        rready;
	core_pkg::commit_t           commit;
	logic                        commit_valid;

	commit_exp_t exp_commit [NUM_COMMITS];
	logic [31:0] lfsr_state = 32'd68601;
	int          error_count = 0;
	int          commit_count = 0;
	int          req_count = 0;
	int          cycle_count = 0;
	logic        in_flight = 1'b0;
	logic        seen_request = 1'b0;

	`include "isa_model.svh"

	core_top core_top_inst (
		.clk          (clk),
		.rst          (rst),
		.araddr       (araddr),
		.arvalid      (arvalid),
		.arready      (arready),
		.rdata        (rdata),
		.rvalid       (rvalid),
		.rready       (rready),
		.commit       (commit),
		.commit_valid (commit_valid)
	);

	always #2 clk = ~clk;

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] expected);
		if (got !== expected) begin
			error_count++;
			$display("[ERROR] %0t ns %s: got 0x%08h, expected 0x%08h",
				$time, name, got, expected);
		end
	endtask

	task automatic report_problem(input string msg);
		error_count++;
		$display("%s (at %0t ns)", msg, $time);
	endtask

	// three LFSR bits give 0 to 7 cycles
	task automatic draw_delay(output logic [2:0] delay);
		delay = '0;
		repeat (3) begin
			lfsr_state = lfsr_step(lfsr_state);
			delay = {delay[1:0], lfsr_state[0]};
		end
	endtask

	// one read, request phase then response phase
	task automatic serve_request();
		logic [`CORE_DATA_WIDTH-1:0] addr;
		logic [2:0]                  delay;
		addr = araddr;
		if (in_flight) begin
			report_problem("new request issued before the previous instruction committed");
		end
		if (!in_program(addr)) begin
			report_problem($sformatf("fetch from 0x%08h, outside the program", addr));
		end
		if (req_count < NUM_COMMITS) begin
			check_value("araddr", addr, exp_commit[req_count].pc);
		end
		draw_delay(delay);
		repeat (delay) begin
			@(negedge clk);
			check_value("arvalid", 32'(arvalid), 32'd1);
			check_value("araddr", araddr, addr);
		end
		arready = 1'b1;
		@(negedge clk);
		arready = 1'b0;
		req_count++;
		in_flight = 1'b1;
		draw_delay(delay);
		repeat (delay) begin
			check_value("arvalid", 32'(arvalid), 32'd0);
			check_value("rready", 32'(rready), 32'd1);
			@(negedge clk);
		end
		check_value("rready", 32'(rready), 32'd1);
		rdata = fetch_word(addr);
		rvalid = 1'b1;
		@(negedge clk);
		rvalid = 1'b0;
		check_value("rready", 32'(rready), 32'd0);
	endtask

	// instruction memory
	always begin
		@(negedge clk);
		if (commit_valid) begin
			in_flight = 1'b0;
		end
		if (!rst && arvalid) begin
			serve_request();
		end
	end

	task automatic compare_commit();
		commit_exp_t e;
		if (commit_count < NUM_COMMITS) begin
			e = exp_commit[commit_count];
			check_value("commit.pc", commit.pc, e.pc);
			check_value("commit.wen", 32'(commit.wen), 32'(e.wen));
			// rd and data only carry meaning for result-producing ops
			if (e.has_result) begin
				check_value("commit.rd", 32'(commit.rd), 32'(e.rd));
				check_value("commit.data", commit.data, e.data);
			end
		end
		commit_count++;
	endtask

	always @(negedge clk) begin
		if (rst) begin
			check_value("arvalid", 32'(arvalid), 32'd0);
			check_value("rready", 32'(rready), 32'd0);
			check_value("commit_valid", 32'(commit_valid), 32'd0);
		end else begin
			if (!seen_request) begin
				if (arvalid) begin
					seen_request = 1'b1;
				end else begin
					check_value("rready", 32'(rready), 32'd0);
					check_value("commit_valid", 32'(commit_valid), 32'd0);
				end
			end
			if (commit_valid) begin
				compare_commit();
			end
		end
	end

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("run stopped after %0d cycles with %0d of %0d commits seen",
				cycle_count, commit_count, NUM_COMMITS);
			$display("errors: %0d, commits: %0d, requests: %0d",
				error_count, commit_count, req_count);
			$display("Finished with errors");
			$finish;
		end
	end

	initial begin
		run_model();
		repeat (16) @(negedge clk);
		rst = 1'b0;
		wait (commit_count == NUM_COMMITS);
		repeat (2) @(posedge clk);
		// at most one request may be open past the last commit
		if (req_count < commit_count || req_count > commit_count + 1) begin
			report_problem($sformatf("%0d requests issued for %0d commits",
				req_count, commit_count));
		end
		$display("errors: %0d, commits: %0d, requests: %0d",
			error_count, commit_count, req_count);
		if (error_count == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== logic/core_top.sv ====
// multicycle core top level
`timescale 1ns/1ps
`include "core_defines.svh"
`default_nettype none

module core_top (
	input  logic                        clk,
	input  logic                        rst,
	output logic [`CORE_DATA_WIDTH-1:0] araddr,
	output logic                        arvalid,
	input  logic                        arready,
	input  logic [`CORE_DATA_WIDTH-1:0] rdata,
	input  logic                        rvalid,
	output logic                        rready,
	output core_pkg::commit_t           commit,
	output logic                        commit_valid
);

	core_pkg::fetch_bus_t  ifu_to_idu_bus;
	core_pkg::decode_bus_t idu_to_exu_bus;
	core_pkg::redirect_t   redirect;
	logic                  ifu_to_idu_valid;
	logic                  idu_valid;
	logic                  exu_allowin;
	logic                  exu_to_ifu_valid;

	fetch_unit u_fetch (
		.clk              (clk),
		.rst              (rst),
		.redirect         (redirect),
		.exu_to_ifu_valid (exu_to_ifu_valid),
		.exu_allowin      (exu_allowin),
		.idu_valid        (idu_valid),
		.ifu_to_idu_bus   (ifu_to_idu_bus),
		.ifu_to_idu_valid (ifu_to_idu_valid),
		.araddr           (araddr),
		.arvalid          (arvalid),
		.arready          (arready),
		.rdata            (rdata),
		.rvalid           (rvalid),
		.rready           (rready)
	);

	decode_unit u_decode (
		.clk              (clk),
		.rst              (rst),
		.ifu_to_idu_bus   (ifu_to_idu_bus),
		.ifu_to_idu_valid (ifu_to_idu_valid),
		.exu_allowin      (exu_allowin),
		.idu_to_exu_bus   (idu_to_exu_bus),
		.idu_valid        (idu_valid)
	);

	exec_unit u_exec (
		.clk              (clk),
		.rst              (rst),
		.idu_to_exu_bus   (idu_to_exu_bus),
		.idu_valid        (idu_valid),
		.exu_allowin      (exu_allowin),
		.redirect         (redirect),
		.exu_to_ifu_valid (exu_to_ifu_valid),
		.commit           (commit),
		.commit_valid     (commit_valid)
	);

endmodule

`default_nettype wire

// ==== logic/exec_unit.sv ====
// execute and write-back unit
`timescale 1ns/1ps
`include "core_defines.svh"
`default_nettype none

module exec_unit (
	input  logic                  clk,
	input  logic                  rst,
	input  core_pkg::decode_bus_t idu_to_exu_bus,
	input  logic                  idu_valid,
	output logic                  exu_allowin,
	output core_pkg::redirect_t   redirect,
	output logic                  exu_to_ifu_valid,
	output core_pkg::commit_t     commit,
	output logic                  commit_valid
);

	logic [`CORE_DATA_WIDTH-1:0] src1;
	logic [`CORE_DATA_WIDTH-1:0] src2;
	logic [`CORE_DATA_WIDTH-1:0] result;
	logic [`CORE_DATA_WIDTH-1:0] seq_pc;
	logic [`CORE_DATA_WIDTH-1:0] target;
	logic                        wr;
	logic                        taken;
	logic                        take;

	// every instruction finishes in the cycle it is taken
	assign exu_allowin = 1'b1;
	assign take = idu_valid && exu_allowin;

	reg_file u_reg_file (
		.clk    (clk),
		.rst    (rst),
		.raddr1 (idu_to_exu_bus.rs1),
		.raddr2 (idu_to_exu_bus.rs2),
		.rdata1 (src1),
		.rdata2 (src2),
		.wen    (commit_valid && commit.wen),
		.waddr  (commit.rd),
		.wdata  (commit.data)
	);

	assign seq_pc = idu_to_exu_bus.pc + `CORE_PC_STEP;
	assign target = idu_to_exu_bus.pc + idu_to_exu_bus.imm;

	always_comb begin
		result = '0;
		wr = 1'b0;
		taken = 1'b0;
		case (idu_to_exu_bus.op)
			core_pkg::op_add: begin
				result = src1 + src2;
				wr = 1'b1;
			end
			core_pkg::op_addi: begin
				result = src1 + idu_to_exu_bus.imm;
				wr = 1'b1;
			end
			core_pkg::op_lui: begin
				result = idu_to_exu_bus.imm;
				wr = 1'b1;
			end
			core_pkg::op_beq: begin
				taken = (src1 == src2);
			end
			core_pkg::op_bne: begin
				taken = (src1 != src2);
			end
			core_pkg::op_jal: begin
				// link address
				result = seq_pc;
				wr = 1'b1;
				taken = 1'b1;
			end
			default: begin
				wr = 1'b0;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			commit_valid <= 1'b0;
			exu_to_ifu_valid <= 1'b0;
		end else begin
			commit_valid <= take;
			exu_to_ifu_valid <= take;
		end
	end

	// commit and redirect land together
	always_ff @(posedge clk) begin
		if (take) begin
			commit.pc <= idu_to_exu_bus.pc;
			commit.rd <= idu_to_exu_bus.rd;
			commit.data <= result;
			commit.wen <= wr && (idu_to_exu_bus.rd != 5'd0);
			redirect.taken <= taken;
			redirect.pc <= taken ? target : seq_pc;
		end
	end

	// one instruction in flight, so retirements never come back to back
	a_commit_pulse: assert property (@(posedge clk) disable iff (rst)
		commit_valid |=> !commit_valid);

endmodule

`default_nettype wire

// ==== logic/decode_unit.sv ====
// instruction decode unit
`timescale 1ns/1ps
`include "core_defines.svh"
`default_nettype none

module decode_unit (
	input  logic                  clk,
	input  logic                  rst,
	input  core_pkg::fetch_bus_t  ifu_to_idu_bus,
	input  logic                  ifu_to_idu_valid,
	input  logic                  exu_allowin,
	output core_pkg::decode_bus_t idu_to_exu_bus,
	output logic                  idu_valid
);

	core_pkg::fetch_bus_t fetch_r;
	core_pkg::rv_inst_u   inst;
	core_pkg::op_e        op;
	logic [`CORE_DATA_WIDTH-1:0] imm;

	always_ff @(posedge clk) begin
		if (ifu_to_idu_valid) begin
			fetch_r <= ifu_to_idu_bus;
		end
	end

	// held until execute takes it
	always_ff @(posedge clk) begin
		if (rst) begin
			idu_valid <= 1'b0;
		end else if (ifu_to_idu_valid) begin
			idu_valid <= 1'b1;
		end else if (idu_valid && exu_allowin) begin
			idu_valid <= 1'b0;
		end
	end

	assign inst = fetch_r.inst;

	always_comb begin
		op = core_pkg::op_nop;
		imm = '0;
		case (inst.r.opcode)
			core_pkg::opc_reg: begin
				if (inst.r.funct3 == 3'b000 && inst.r.funct7 == 7'b0000000) begin
					op = core_pkg::op_add;
				end
			end
			core_pkg::opc_imm: begin
				if (inst.i.funct3 == 3'b000) begin
					op = core_pkg::op_addi;
				end
				imm = {{20{inst.i.imm[11]}}, inst.i.imm};
			end
			core_pkg::opc_lui: begin
				op = core_pkg::op_lui;
				imm = {inst.u.imm, 12'b0};
			end
			core_pkg::opc_branch: begin
				if (inst.r.funct3 == 3'b000) begin
					op = core_pkg::op_beq;
				end else if (inst.r.funct3 == 3'b001) begin
					op = core_pkg::op_bne;
				end
				// B immediate lives in the funct7 and rd slots
				imm = {{19{inst.r.funct7[6]}}, inst.r.funct7[6], inst.r.rd[0],
					inst.r.funct7[5:0], inst.r.rd[4:1], 1'b0};
			end
			core_pkg::opc_jal: begin
				op = core_pkg::op_jal;
				imm = {{11{inst.u.imm[19]}}, inst.u.imm[19], inst.u.imm[7:0],
					inst.u.imm[8], inst.u.imm[18:9], 1'b0};
			end
			default: begin
				op = core_pkg::op_nop;
			end
		endcase
	end

	assign idu_to_exu_bus.pc = fetch_r.pc;
	assign idu_to_exu_bus.op = op;
	assign idu_to_exu_bus.rs1 = inst.r.rs1;
	assign idu_to_exu_bus.rs2 = inst.r.rs2;
	assign idu_to_exu_bus.rd = inst.r.rd;
	assign idu_to_exu_bus.imm = imm;

	// fetch never overruns a held instruction
	a_no_overrun: assert property (@(posedge clk) disable iff (rst)
		ifu_to_idu_valid |-> !idu_valid);

endmodule

`default_nettype wire

// ==== logic/fetch_unit.sv ====
// instruction fetch unit
`timescale 1ns/1ps
`include "core_defines.svh"
`default_nettype none

module fetch_unit (
	input  logic                        clk,
	input  logic                        rst,
	input  core_pkg::redirect_t         redirect,
	input  logic                        exu_to_ifu_valid,
	input  logic                        exu_allowin,
	input  logic                        idu_valid,
	output core_pkg::fetch_bus_t        ifu_to_idu_bus,
	output logic                        ifu_to_idu_valid,
	output logic [`CORE_DATA_WIDTH-1:0] araddr,
	output logic                        arvalid,
	input  logic                        arready,
	input  logic [`CORE_DATA_WIDTH-1:0] rdata,
	input  logic                        rvalid,
	output logic                        rready
);

	typedef enum logic [2:0] {
		idle_r,
		wait_arready,
		shaked_ar,
		wait_rvalid,
		shaked_r
	} rd_state_e;

	rd_state_e                   state;
	rd_state_e                   state_next;
	logic [`CORE_DATA_WIDTH-1:0] pc;
	logic [`CORE_DATA_WIDTH-1:0] nextpc;
	logic [`CORE_DATA_WIDTH-1:0] inst_r;
	logic                        first_fetch;
	logic                        ifu_allowin;
	logic                        start;

	// nothing downstream and nothing held here
	assign ifu_allowin = !idu_valid && exu_allowin && !ifu_to_idu_valid;

	// later fetches wait for the redirect from execute
	assign start = ifu_allowin && (first_fetch || exu_to_ifu_valid);

	always_comb begin
		if (first_fetch) begin
			nextpc = `CORE_RESET_PC;
		end else if (redirect.taken) begin
			nextpc = redirect.pc;
		end else begin
			nextpc = pc + `CORE_PC_STEP;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= idle_r;
		end else begin
			state <= state_next;
		end
	end

	always_comb begin
		state_next = state;
		case (state)
			idle_r: begin
				if (start) begin
					state_next = wait_arready;
				end
			end
			wait_arready: begin
				if (arvalid && arready) begin
					state_next = shaked_ar;
				end
			end
			shaked_ar: begin
				state_next = (rvalid && rready) ? shaked_r : wait_rvalid;
			end
			wait_rvalid: begin
				if (rvalid && rready) begin
					state_next = shaked_r;
				end
			end
			shaked_r: begin
				state_next = idle_r;
			end
			default: begin
				state_next = idle_r;
			end
		endcase
	end

	// handshake strobes follow the next state, one cycle registered
	always_ff @(posedge clk) begin
		if (rst) begin
			arvalid <= 1'b0;
			rready <= 1'b0;
			ifu_to_idu_valid <= 1'b0;
		end else begin
			arvalid <= (state_next == wait_arready);
			rready <= (state_next == shaked_ar) || (state_next == wait_rvalid);
			ifu_to_idu_valid <= (state_next == shaked_r);
		end
	end

	// pc moves once the memory has taken the address
	always_ff @(posedge clk) begin
		if (rst) begin
			pc <= `CORE_RESET_PC;
			first_fetch <= 1'b1;
		end else if (arvalid && arready) begin
			pc <= nextpc;
			first_fetch <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (state == idle_r && start) begin
			araddr <= nextpc;
		end
	end

	always_ff @(posedge clk) begin
		if (rvalid && rready) begin
			inst_r <= rdata;
		end
	end

	assign ifu_to_idu_bus.pc = pc;
	assign ifu_to_idu_bus.inst = inst_r;

	// request held until the memory takes it
	a_araddr_stable: assert property (@(posedge clk) disable iff (rst)
		arvalid && !arready |=> arvalid && $stable(araddr));

	// address and data phases never overlap
	a_phase_excl: assert property (@(posedge clk) disable iff (rst)
		!(arvalid && rready));

endmodule

`default_nettype wire

// ==== logic/reg_file.sv ====
// integer register file
`timescale 1ns/1ps
`include "core_defines.svh"
`default_nettype none

module reg_file (
	input  logic                        clk,
	input  logic                        rst,
	input  logic [4:0]                  raddr1,
	input  logic [4:0]                  raddr2,
	output logic [`CORE_DATA_WIDTH-1:0] rdata1,
	output logic [`CORE_DATA_WIDTH-1:0] rdata2,
	input  logic                        wen,
	input  logic [4:0]                  waddr,
	input  logic [`CORE_DATA_WIDTH-1:0] wdata
);

	logic [`CORE_DATA_WIDTH-1:0] regs [32];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (wen && waddr != 5'd0) begin
			regs[waddr] <= wdata;
		end
	end

	// x0 always reads zero
	assign rdata1 = (raddr1 == 5'd0) ? '0 : regs[raddr1];
	assign rdata2 = (raddr2 == 5'd0) ? '0 : regs[raddr2];

endmodule

`default_nettype wire

// ==== logic/core_pkg.sv ====
// core shared types
`default_nettype none
`include "core_defines.svh"

package core_pkg;

	// major opcodes of the supported subset
	typedef enum logic [6:0] {
		opc_reg    = 7'b0110011,
		opc_imm    = 7'b0010011,
		opc_lui    = 7'b0110111,
		opc_branch = 7'b1100011,
		opc_jal    = 7'b1101111
	} opcode_e;

	// operation selected by decode
	typedef enum logic [2:0] {
		op_add,
		op_addi,
		op_lui,
		op_beq,
		op_bne,
		op_jal,
		op_nop
	} op_e;

	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} rv_r_t;

	typedef struct packed {
		logic [11:0] imm;
		logic [4:0]  rs1;
		logic [2:0]  funct3;
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} rv_i_t;

	typedef struct packed {
		logic [19:0] imm;
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} rv_u_t;

	// one instruction word, three field layouts
	typedef union packed {
		rv_r_t r;
		rv_i_t i;
		rv_u_t u;
	} rv_inst_u;

	// fetch to decode
	typedef struct packed {
		logic [`CORE_DATA_WIDTH-1:0] pc;
		logic [`CORE_DATA_WIDTH-1:0] inst;
	} fetch_bus_t;

	// decode to execute
	typedef struct packed {
		logic [`CORE_DATA_WIDTH-1:0] pc;
		op_e                         op;
		logic [4:0]                  rs1;
		logic [4:0]                  rs2;
		logic [4:0]                  rd;
		logic [`CORE_DATA_WIDTH-1:0] imm;
	} decode_bus_t;

	// execute to fetch
	typedef struct packed {
		logic                        taken;
		logic [`CORE_DATA_WIDTH-1:0] pc;
	} redirect_t;

	// retired instruction
	typedef struct packed {
		logic [`CORE_DATA_WIDTH-1:0] pc;
		logic [4:0]                  rd;
		logic [`CORE_DATA_WIDTH-1:0] data;
		logic                        wen;
	} commit_t;

endpackage

`default_nettype wire

// ==== logic/core_defines.svh ====
// core configuration macros
`ifndef CORE_DEFINES_SVH
`define CORE_DEFINES_SVH

// width of data words, registers and addresses
`define CORE_DATA_WIDTH 32

// address of the first instruction fetched after reset
`define CORE_RESET_PC 32'h0000_0000

// byte step between sequential instructions
`define CORE_PC_STEP 32'd4

`endif
